// ==== Makefile ====
# Verilator build and run of the fetch front end testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal -f fetch_top.f --top-module fetch_tb -o fetch_sim
	./obj_dir/fetch_sim | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== fetch_top.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_stage_reg.sv
verilog/fetch_addr_select.sv
verilog/fetch_tlb.sv
verilog/fetch_icache_bank.sv
verilog/fetch_top.sv
tb/fetch_clk_gen.sv
tb/fetch_tb.sv

// ==== include/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// address widths
`define FETCH_ADDR_W       32
`define FETCH_LINE_OFS     4     // 16-byte lines
`define FETCH_FIP_W        28    // line address, ADDR_W - LINE_OFS

// line payload
`define FETCH_LINE_W       128

// paging and TLB
`define FETCH_PAGE_OFS     12
`define FETCH_TLB_ENTRIES  8

// sets in each direct-mapped bank
`define FETCH_BANK_SETS    16

`endif

// ==== tb/fetch_clk_gen.sv ====
`timescale 1ns/1ps

module fetch_clk_gen #(
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        forever #4 clk_o = ~clk_o;   // 8 ns period
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb;
    import fetch_pkg::*;

    // test lengths in cycles
    localparam int LEN_IDLE     = 24;
    localparam int LEN_INIT_ADV = 120;
    localparam int LEN_PRIORITY = 160;
    localparam int LEN_TLB      = 120;
    localparam int LEN_FILL     = 80;
    localparam int LEN_MISSES   = 200;
    localparam int CYCLE_LIMIT  = LEN_IDLE + LEN_INIT_ADV + LEN_PRIORITY + LEN_TLB
                                  + LEN_FILL + LEN_MISSES + 64;   // reset, drain, margin

    logic                                  clk;
    logic                                  reset;
    logic                                  init;
    logic [`FETCH_ADDR_W-1:0]              init_addr;
    logic                                  resteer;
    fip_t                                  wb_fip_e;
    fip_t                                  wb_fip_o;
    logic                                  br_taken;
    fip_t                                  bp_fip_e;
    fip_t                                  bp_fip_o;
    logic                                  adv_e;
    logic                                  adv_o;
    logic                                  tlb_wr;
    logic [$clog2(`FETCH_TLB_ENTRIES)-1:0] tlb_wr_idx;
    tlb_entry_t                            tlb_wr_entry;
    fill_rsp_t                             fill_rsp_e;
    fill_rsp_t                             fill_rsp_o;
    fill_req_t                             fill_req_e;
    fill_req_t                             fill_req_o;
    fetch_line_t                           line_e;
    fetch_line_t                           line_o;

    // reference model state, index 0 even and 1 odd
    fip_t                     m_fip_q  [2];
    logic                     m_s1_v   [2];
    fip_t                     m_s1_fip [2];
    logic                     m_s2_v   [2];
    xlat_t                    m_s2_x   [2];
    tlb_entry_t               m_tlb    [`FETCH_TLB_ENTRIES];
    logic                     m_set_v  [2][`FETCH_BANK_SETS];
    logic [22:0]              m_tag    [2][`FETCH_BANK_SETS];
    logic [`FETCH_LINE_W-1:0] m_data   [2][`FETCH_BANK_SETS];
    logic                     m_pend   [2];
    int                       mem_wait [2];
    fip_t                     mem_addr [2];
    fetch_line_t              exp_line [2];
    fill_req_t                exp_req  [2];

    logic [31:0] stim_lfsr = 32'h42d4;
    logic [31:0] mem_lfsr  = 32'h42d4;
    int          cycle     = 0;
    int          n_checks  = 0;
    int          n_errors  = 0;

    fetch_clk_gen u_clk_gen (.clk_o(clk), .reset_o(reset));

    fetch_top dut_i (
        .clk(clk), .reset_i(reset), .init_i(init), .init_addr_i(init_addr),
        .resteer_i(resteer), .wb_fip_e_i(wb_fip_e), .wb_fip_o_i(wb_fip_o),
        .br_taken_i(br_taken), .bp_fip_e_i(bp_fip_e), .bp_fip_o_i(bp_fip_o),
        .adv_e_i(adv_e), .adv_o_i(adv_o), .tlb_wr_i(tlb_wr), .tlb_wr_idx_i(tlb_wr_idx),
        .tlb_wr_entry_i(tlb_wr_entry), .fill_rsp_e_i(fill_rsp_e), .fill_rsp_o_i(fill_rsp_o),
        .fill_req_e_o(fill_req_e), .fill_req_o_o(fill_req_o),
        .line_e_o(line_e), .line_o_o(line_o));

    //////////////////////////////
    // random numbers
    //////////////////////////////
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            r = {r[30:0], stim_lfsr[0]};   // one step per bit
        end
        return r;
    endfunction

    // memory latency draw, own stream
    function automatic logic [2:0] mem_delay();
        logic [2:0] d;
        d = '0;
        for (int i = 0; i < 3; i++) begin
            mem_lfsr = lfsr_step(mem_lfsr);
            d = {d[1:0], mem_lfsr[0]};
        end
        return d;
    endfunction

    // pages 0 to 15, or only the plain mapped pages 0 to 3
    function automatic fip_t target_fip(logic parity, logic mapped_only);
        fip_t f;
        f = '0;
        f[11:0] = 12'(rand_bits(12));
        if (mapped_only) begin
            f[11:10] = 2'b00;
        end
        f[0] = parity;
        return f;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic xlat_t xlate(fip_t f);
        xlat_t x;
        x.vfip     = f;
        x.pfip     = '0;
        x.tlb_miss = 1'b1;
        x.prot_exc = 1'b0;
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            if (m_tlb[i].valid && m_tlb[i].present && m_tlb[i].vpn == f[27:8]) begin
                x.pfip     = {m_tlb[i].pfn, f[7:0]};
                x.tlb_miss = 1'b0;
                x.prot_exc = m_tlb[i].pcd;   // no fetch from an uncacheable page
            end
        end
        return x;
    endfunction

    task automatic model_reset();
        for (int p = 0; p < 2; p++) begin
            m_fip_q[p]  = fip_t'(p);   // odd stream sits on line 1
            m_s1_v[p]   = 1'b0;
            m_s1_fip[p] = '0;
            m_s2_v[p]   = 1'b0;
            m_s2_x[p]   = '0;
            m_pend[p]   = 1'b0;
            mem_wait[p] = 0;
            exp_line[p] = '0;
            exp_req[p]  = '0;
            for (int s = 0; s < `FETCH_BANK_SETS; s++) begin
                m_set_v[p][s] = 1'b0;
            end
        end
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            m_tlb[i] = '0;
        end
        fill_rsp_e <= '0;
        fill_rsp_o <= '0;
    endtask

    // memory answers a pending request when its count runs out
    task automatic mem_step();
        fill_rsp_t rsp [2];
        for (int p = 0; p < 2; p++) begin
            rsp[p] = '0;
            if (mem_wait[p] > 0) begin
                mem_wait[p] = mem_wait[p] - 1;
                if (mem_wait[p] == 0) begin
                    rsp[p].valid = 1'b1;
                    rsp[p].pfip  = mem_addr[p];
                    rsp[p].line  = {4{4'h0, mem_addr[p]}};   // address repeated
                end
            end
        end
        fill_rsp_e <= rsp[0];
        fill_rsp_o <= rsp[1];
    endtask

    task automatic bank_step(int p, fill_rsp_t rsp);
        logic [3:0]  idx;
        logic [3:0]  fidx;
        logic [22:0] tag;
        logic        exc;
        logic        tag_hit;
        logic        req;
        idx     = m_s2_x[p].pfip[4:1];   // set index sits above the parity bit
        tag     = m_s2_x[p].pfip[27:5];
        exc     = m_s2_x[p].tlb_miss | m_s2_x[p].prot_exc;
        tag_hit = m_set_v[p][idx] && (m_tag[p][idx] == tag);
        req     = m_s2_v[p] && !exc && !tag_hit && !m_pend[p];
        exp_line[p].valid     = m_s2_v[p];
        exp_line[p].hit       = m_s2_v[p] && tag_hit && !exc && !rsp.valid;
        exp_line[p].refilling = rsp.valid;
        exp_line[p].tlb_miss  = m_s2_x[p].tlb_miss;
        exp_line[p].prot_exc  = m_s2_x[p].prot_exc;
        exp_line[p].fip_lsb   = m_s2_x[p].vfip[1:0];
        exp_line[p].line      = m_data[p][idx];
        exp_req[p].valid      = req;
        exp_req[p].pfip       = m_s2_x[p].pfip;
        if (req) begin
            m_pend[p]   = 1'b1;
            mem_addr[p] = m_s2_x[p].pfip;
            mem_wait[p] = 1 + int'(mem_delay());   // 1 to 8 cycles
        end else if (rsp.valid) begin
            m_pend[p] = 1'b0;
        end
        if (rsp.valid) begin
            fidx            = rsp.pfip[4:1];
            m_set_v[p][fidx] = 1'b1;
            m_tag[p][fidx]   = rsp.pfip[27:5];
            m_data[p][fidx]  = rsp.line;
        end
    endtask

    task automatic select_step(int p);
        fip_t init_line;
        fip_t first;
        fip_t wb;
        fip_t bp;
        fip_t cf_fip;
        logic cf;
        logic adv;
        init_line = init_addr[31:4];
        // odd stream rounds up to an odd line, even stream to an even one
        first     = p[0] ? (init_line | 28'd1) : ((init_line + 28'd1) & ~28'd1);
        wb        = (p == 1) ? wb_fip_o : wb_fip_e;
        bp        = (p == 1) ? bp_fip_o : bp_fip_e;
        adv       = (p == 1) ? adv_o : adv_e;
        cf        = init | resteer | br_taken;
        cf_fip    = init ? first : (resteer ? wb : bp);
        // translate moves on, a redirect drops it
        m_s2_x[p]   = xlate(m_s1_fip[p]);
        m_s2_v[p]   = m_s1_v[p] && !cf;
        m_s1_fip[p] = cf ? cf_fip : m_fip_q[p];
        m_s1_v[p]   = 1'b1;
        if (cf) begin
            m_fip_q[p] = cf_fip;
        end else if (adv) begin
            m_fip_q[p] = m_fip_q[p] + 28'd2;   // next line of same parity
        end
    endtask

    always @(posedge clk) begin
        fill_rsp_t rsp_now [2];
        rsp_now[0] = fill_rsp_e;
        rsp_now[1] = fill_rsp_o;
        if (reset) begin
            model_reset();
        end else begin
            mem_step();
            for (int p = 0; p < 2; p++) begin
                bank_step(p, rsp_now[p]);
                select_step(p);
            end
            if (tlb_wr) begin
                m_tlb[tlb_wr_idx] = tlb_wr_entry;   // both TLBs see it next cycle
            end
        end
    end

    //////////////////////////////
    // compare
    //////////////////////////////
    task automatic check_line(string name, fetch_line_t got, fetch_line_t exp);
        n_checks++;
        if (got.valid !== exp.valid || got.hit !== exp.hit || got.refilling !== exp.refilling
            || (exp.valid && (got.tlb_miss !== exp.tlb_miss || got.prot_exc !== exp.prot_exc
                              || got.fip_lsb !== exp.fip_lsb))
            || (exp.hit && got.line !== exp.line)) begin
            n_errors++;
            $display("ERROR %s got %h expected %h, cycle %0d", name, got, exp, cycle);
        end
    endtask

    task automatic check_req(string name, fill_req_t got, fill_req_t exp);
        n_checks++;
        if (got.valid !== exp.valid || (exp.valid && got.pfip !== exp.pfip)) begin
            n_errors++;
            $display("ERROR %s got %h expected %h, cycle %0d", name, got, exp, cycle);
        end
    endtask

    // outputs are settled halfway through the cycle
    always @(negedge clk) begin
        if (!reset) begin
            check_line("line_e_o", line_e, exp_line[0]);
            check_line("line_o_o", line_o, exp_line[1]);
            check_req("fill_req_e_o", fill_req_e, exp_req[0]);
            check_req("fill_req_o_o", fill_req_o, exp_req[1]);
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("run stopped, no end after %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    task automatic init_inputs();
        init         = 1'b0;
        init_addr    = '0;
        resteer      = 1'b0;
        wb_fip_e     = '0;
        wb_fip_o     = 28'd1;
        br_taken     = 1'b0;
        bp_fip_e     = '0;
        bp_fip_o     = 28'd1;
        adv_e        = 1'b0;
        adv_o        = 1'b0;
        tlb_wr       = 1'b0;
        tlb_wr_idx   = '0;
        tlb_wr_entry = '0;
        fill_rsp_e   = '0;
        fill_rsp_o   = '0;
    endtask

    // page i on entry i, page 6 uncacheable, page 7 not present
    task automatic load_tlb_entry(int i);
        tlb_entry_t e;
        e.vpn        = 20'(i);
        e.pfn        = 20'(rand_bits(20));
        e.valid      = 1'b1;
        e.present    = (i != 7);
        e.pcd        = (i == 6);
        tlb_wr       <= 1'b1;
        tlb_wr_idx   <= 3'(i);
        tlb_wr_entry <= e;
    endtask

    task automatic random_targets(logic mapped_only);
        wb_fip_e <= target_fip(1'b0, mapped_only);
        wb_fip_o <= target_fip(1'b1, mapped_only);
        bp_fip_e <= target_fip(1'b0, mapped_only);
        bp_fip_o <= target_fip(1'b1, mapped_only);
    endtask

    task automatic drive_cycle(int mode, int c);
        init     <= 1'b0;
        resteer  <= 1'b0;
        br_taken <= 1'b0;
        adv_e    <= 1'b0;
        adv_o    <= 1'b0;
        tlb_wr   <= 1'b0;
        case (mode)
            2: begin
                if (c < `FETCH_TLB_ENTRIES) begin
                    load_tlb_entry(c);
                end else if (c == `FETCH_TLB_ENTRIES || rand_bits(4) == 0) begin
                    init      <= 1'b1;
                    init_addr <= {target_fip(1'(rand_bits(1)), 1'b0), 4'(rand_bits(4))};
                end else begin
                    adv_e <= 1'(rand_bits(1));
                    adv_o <= 1'(rand_bits(1));
                end
            end
            3: begin
                init      <= (rand_bits(2) == 0);
                resteer   <= (rand_bits(2) == 0);
                br_taken  <= (rand_bits(2) == 0);
                init_addr <= {target_fip(1'(rand_bits(1)), 1'b0), 4'(rand_bits(4))};
                random_targets(1'b0);
                adv_e     <= 1'(rand_bits(1));
                adv_o     <= 1'(rand_bits(1));
            end
            4: begin
                resteer <= 1'(rand_bits(1));   // unmapped, uncacheable and plain pages
                random_targets(1'b0);
                adv_e   <= 1'(rand_bits(1));
                adv_o   <= 1'(rand_bits(1));
            end
            5: begin
                if (c == 0 || c == 40) begin
                    br_taken <= 1'b1;   // same two lines, stream then holds
                    bp_fip_e <= 28'h000_0240;
                    bp_fip_o <= 28'h000_0241;
                end
            end
            6: begin
                resteer <= 1'(rand_bits(1));
                random_targets(1'b1);
                adv_e   <= 1'(rand_bits(1));
                adv_o   <= 1'(rand_bits(1));
            end
            default: begin
            end
        endcase
    endtask

    task automatic run_test(int mode, string name, int len);
        int errs_before;
        errs_before = n_errors;
        for (int c = 0; c < len; c++) begin
            @(posedge clk);
            drive_cycle(mode, c);
        end
        $display("test %0d %s: %0d cycles, %0d errors", mode, name, len,
                 n_errors - errs_before);
    endtask

    initial begin
        init_inputs();
        while (reset !== 1'b0) begin
            @(posedge clk);
        end
        run_test(1, "idle after reset", LEN_IDLE);
        run_test(2, "init and advance", LEN_INIT_ADV);
        run_test(3, "control flow priority", LEN_PRIORITY);
        run_test(4, "tlb miss and protection", LEN_TLB);
        run_test(5, "miss, fill and hit", LEN_FILL);
        run_test(6, "misses while pending", LEN_MISSES);
        // let the pipeline and memory drain
        repeat (12) begin
            @(posedge clk);
            drive_cycle(1, 0);
        end
        @(negedge clk);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/fetch_addr_select.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_addr_select #(
    parameter int PARITY = 0
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     init_i,
    input  logic [`FETCH_ADDR_W-1:0] init_addr_i,
    input  logic                     resteer_i,
    input  fetch_pkg::fip_t          wb_fip_i,
    input  logic                     br_taken_i,
    input  fetch_pkg::fip_t          bp_fip_i,
    input  logic                     adv_i,
    output fetch_pkg::fip_t          fip_o
);
    import fetch_pkg::*;

    fip_t                    init_line;
    fip_t                    init_fip;
    fip_t                    cf_fip;
    logic                    is_cf;
    logic [`FETCH_FIP_W-2:0] fip_hi_q;   // line bits above the parity bit

    //////////////////////////////
    // init line for this parity
    //////////////////////////////
    assign init_line = init_addr_i[`FETCH_ADDR_W-1:`FETCH_LINE_OFS];
    // first line of our parity at or above the init line
    assign init_fip  = (init_line[0] == PARITY[0]) ? init_line : init_line + 1'b1;

    //////////////////////////////
    // control flow priority
    //////////////////////////////
    assign is_cf = init_i | resteer_i | br_taken_i;

    always_comb begin
        if (init_i) begin
            cf_fip = init_fip;
        end else if (resteer_i) begin
            cf_fip = wb_fip_i;   // writeback resteer
        end else begin
            cf_fip = bp_fip_i;
        end
    end

    // next-line register, parity bit is implied
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fip_hi_q <= '0;
        end else if (is_cf) begin
            fip_hi_q <= cf_fip[`FETCH_FIP_W-1:1];
        end else if (adv_i) begin
            fip_hi_q <= fip_hi_q + 1'b1;   // +1 here is two lines
        end
    end

    // control flow address bypasses the register
    assign fip_o = is_cf ? cf_fip : {fip_hi_q, PARITY[0]};

    // predictor and writeback must hand this stream lines of its own parity
    a_fip_parity: assert property (@(posedge clk) disable iff (reset_i)
        fip_o[0] == PARITY[0]);

endmodule

// ==== verilog/fetch_icache_bank.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_icache_bank #(
    parameter int PARITY = 0
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   valid_i,
    input  fetch_pkg::xlat_t       xlat_i,
    input  fetch_pkg::fill_rsp_t   fill_rsp_i,
    output fetch_pkg::fill_req_t   fill_req_o,
    output fetch_pkg::fetch_line_t line_o
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`FETCH_BANK_SETS);
    localparam int TAG_W = `FETCH_FIP_W - IDX_W - 1;   // parity bit is not stored

    logic [TAG_W-1:0]         tag_q  [`FETCH_BANK_SETS];
    logic [`FETCH_LINE_W-1:0] data_q [`FETCH_BANK_SETS];
    logic [`FETCH_BANK_SETS-1:0] set_valid_q;
    logic                     outstanding_q;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] fill_idx;
    logic             exc;
    logic             tag_hit;
    logic             req_c;

    // registered results
    logic                     res_valid_q;
    logic                     res_hit_q;
    logic                     res_refill_q;
    logic                     res_tlb_miss_q;
    logic                     res_prot_exc_q;
    logic [1:0]               res_lsb_q;
    logic [`FETCH_LINE_W-1:0] res_line_q;
    logic                     req_valid_q;
    fip_t                     req_pfip_q;

    assign idx      = xlat_i.pfip[IDX_W:1];
    assign tag      = xlat_i.pfip[`FETCH_FIP_W-1:IDX_W+1];
    assign fill_idx = fill_rsp_i.pfip[IDX_W:1];
    assign exc      = xlat_i.tlb_miss | xlat_i.prot_exc;
    assign tag_hit  = set_valid_q[idx] && (tag_q[idx] == tag);
    // one miss request at a time
    assign req_c    = valid_i && !exc && !tag_hit && !outstanding_q;

    //////////////////////////////
    // tag and data arrays
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (fill_rsp_i.valid) begin
            tag_q[fill_idx]  <= fill_rsp_i.pfip[`FETCH_FIP_W-1:IDX_W+1];
            data_q[fill_idx] <= fill_rsp_i.line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            set_valid_q <= '0;
        end else if (fill_rsp_i.valid) begin
            set_valid_q[fill_idx] <= 1'b1;
        end
    end

    //////////////////////////////
    // lookup result and miss
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_q   <= 1'b0;
            res_hit_q     <= 1'b0;
            res_refill_q  <= 1'b0;
            req_valid_q   <= 1'b0;
            outstanding_q <= 1'b0;
        end else begin
            res_valid_q  <= valid_i;
            res_hit_q    <= valid_i && tag_hit && !exc && !fill_rsp_i.valid;
            res_refill_q <= fill_rsp_i.valid;   // write cycle, hit forced low
            req_valid_q  <= req_c;
            if (req_c) begin
                outstanding_q <= 1'b1;
            end else if (fill_rsp_i.valid) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        res_tlb_miss_q <= xlat_i.tlb_miss;
        res_prot_exc_q <= xlat_i.prot_exc;
        res_lsb_q      <= xlat_i.vfip[1:0];
        res_line_q     <= data_q[idx];
        req_pfip_q     <= xlat_i.pfip;
    end

    assign line_o = '{valid: res_valid_q, hit: res_hit_q, refilling: res_refill_q,
                      tlb_miss: res_tlb_miss_q, prot_exc: res_prot_exc_q,
                      fip_lsb: res_lsb_q, line: res_line_q};
    assign fill_req_o = '{valid: req_valid_q, pfip: req_pfip_q};

    // a pending request stays pending until its fill, no new one leaves meanwhile
    a_one_request: assert property (@(posedge clk) disable iff (reset_i)
        outstanding_q && !fill_rsp_i.valid |=> outstanding_q && !fill_req_o.valid);

    // memory answers only a pending request, on this bank's parity
    a_fill_parity: assert property (@(posedge clk) disable iff (reset_i)
        fill_rsp_i.valid |-> outstanding_q && (fill_rsp_i.pfip[0] == PARITY[0]));

endmodule

// ==== verilog/fetch_pkg.sv ====
`include "fetch_params.svh"

package fetch_pkg;

    // line address, byte offset dropped
    typedef logic [`FETCH_FIP_W-1:0] fip_t;

    typedef struct packed {
        logic [`FETCH_ADDR_W-`FETCH_PAGE_OFS-1:0] vpn;   // virtual page
        logic [`FETCH_ADDR_W-`FETCH_PAGE_OFS-1:0] pfn;   // page frame
        logic                                     valid;
        logic                                     present;
        logic                                     pcd;   // uncacheable, no fetch allowed
    } tlb_entry_t;

    // translate stage result
    typedef struct packed {
        fip_t vfip;
        fip_t pfip;
        logic tlb_miss;
        logic prot_exc;
    } xlat_t;

    // one bank's result towards the decoder
    typedef struct packed {
        logic                     valid;
        logic                     hit;
        logic                     refilling;   // bank busy writing a fill
        logic                     tlb_miss;
        logic                     prot_exc;
        logic [1:0]               fip_lsb;
        logic [`FETCH_LINE_W-1:0] line;
    } fetch_line_t;

    typedef struct packed {
        logic valid;
        fip_t pfip;
    } fill_req_t;

    typedef struct packed {
        logic                     valid;
        fip_t                     pfip;
        logic [`FETCH_LINE_W-1:0] line;
    } fill_rsp_t;

endpackage

// ==== verilog/fetch_stage_reg.sv ====
`timescale 1ns/1ps

module fetch_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // valid drops on flush, items never wait
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_i;
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// ==== verilog/fetch_tlb.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tlb (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  logic                                   wr_i,
    input  logic [$clog2(`FETCH_TLB_ENTRIES)-1:0]  wr_idx_i,
    input  fetch_pkg::tlb_entry_t                  wr_entry_i,
    input  fetch_pkg::fip_t                        fip_i,
    output fetch_pkg::xlat_t                       xlat_o
);
    import fetch_pkg::*;

    // page offset bits that remain inside a line address
    localparam int VPN_LSB = `FETCH_PAGE_OFS - `FETCH_LINE_OFS;

    tlb_entry_t                    entries_q [`FETCH_TLB_ENTRIES];
    logic [`FETCH_TLB_ENTRIES-1:0] match;
    tlb_entry_t                    hit_entry;
    logic                          any_hit;

    //////////////////////////////
    // entry array
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
                entries_q[i] <= '0;
            end
        end else if (wr_i) begin
            entries_q[wr_idx_i] <= wr_entry_i;   // seen by lookups next cycle
        end
    end

    //////////////////////////////
    // parallel match
    //////////////////////////////
    always_comb begin
        hit_entry = '0;
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            match[i] = entries_q[i].valid && entries_q[i].present
                       && (entries_q[i].vpn == fip_i[`FETCH_FIP_W-1:VPN_LSB]);
            if (match[i]) begin
                hit_entry = entries_q[i];
            end
        end
    end

    assign any_hit = |match;

    always_comb begin
        xlat_o.vfip     = fip_i;
        xlat_o.pfip     = {hit_entry.pfn, fip_i[VPN_LSB-1:0]};   // frame + in-page line
        xlat_o.tlb_miss = ~any_hit;
        xlat_o.prot_exc = any_hit & hit_entry.pcd;   // fetch from uncacheable page
    end

    // the page table writer must never map one page twice
    a_single_match: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(match));

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_top (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic                                  init_i,
    input  logic [`FETCH_ADDR_W-1:0]              init_addr_i,
    input  logic                                  resteer_i,
    input  fetch_pkg::fip_t                       wb_fip_e_i,
    input  fetch_pkg::fip_t                       wb_fip_o_i,
    input  logic                                  br_taken_i,
    input  fetch_pkg::fip_t                       bp_fip_e_i,
    input  fetch_pkg::fip_t                       bp_fip_o_i,
    input  logic                                  adv_e_i,
    input  logic                                  adv_o_i,
    input  logic                                  tlb_wr_i,
    input  logic [$clog2(`FETCH_TLB_ENTRIES)-1:0] tlb_wr_idx_i,
    input  fetch_pkg::tlb_entry_t                 tlb_wr_entry_i,
    input  fetch_pkg::fill_rsp_t                  fill_rsp_e_i,
    input  fetch_pkg::fill_rsp_t                  fill_rsp_o_i,
    output fetch_pkg::fill_req_t                  fill_req_e_o,
    output fetch_pkg::fill_req_t                  fill_req_o_o,
    output fetch_pkg::fetch_line_t                line_e_o,
    output fetch_pkg::fetch_line_t                line_o_o
);
    import fetch_pkg::*;

    logic        ctrl_flow;
    fip_t        wb_fip   [2];
    fip_t        bp_fip   [2];
    logic        adv      [2];
    fill_rsp_t   fill_rsp [2];
    fill_req_t   fill_req [2];
    fetch_line_t line     [2];

    // index 0 is the even stream, 1 the odd one
    assign wb_fip[0]   = wb_fip_e_i;
    assign wb_fip[1]   = wb_fip_o_i;
    assign bp_fip[0]   = bp_fip_e_i;
    assign bp_fip[1]   = bp_fip_o_i;
    assign adv[0]      = adv_e_i;
    assign adv[1]      = adv_o_i;
    assign fill_rsp[0] = fill_rsp_e_i;
    assign fill_rsp[1] = fill_rsp_o_i;

    // items in translate are stale after any redirect
    assign ctrl_flow = init_i | resteer_i | br_taken_i;

    for (genvar p = 0; p < 2; p++) begin : g_stream
        fip_t  fip, s1_fip;
        xlat_t xlat, s2_xlat;
        logic  s1_valid, s2_valid;

        fetch_addr_select #(.PARITY(p)) u_sel (
            .clk(clk), .reset_i(reset_i), .init_i(init_i), .init_addr_i(init_addr_i),
            .resteer_i(resteer_i), .wb_fip_i(wb_fip[p]), .br_taken_i(br_taken_i),
            .bp_fip_i(bp_fip[p]), .adv_i(adv[p]), .fip_o(fip));

        // the new address itself always enters
        fetch_stage_reg #(.payload_t(fip_t)) u_s1 (
            .clk(clk), .reset_i(reset_i), .flush_i(1'b0), .valid_i(1'b1),
            .data_i(fip), .valid_o(s1_valid), .data_o(s1_fip));

        fetch_tlb u_tlb (
            .clk(clk), .reset_i(reset_i), .wr_i(tlb_wr_i), .wr_idx_i(tlb_wr_idx_i),
            .wr_entry_i(tlb_wr_entry_i), .fip_i(s1_fip), .xlat_o(xlat));

        fetch_stage_reg #(.payload_t(xlat_t)) u_s2 (
            .clk(clk), .reset_i(reset_i), .flush_i(ctrl_flow), .valid_i(s1_valid),
            .data_i(xlat), .valid_o(s2_valid), .data_o(s2_xlat));

        fetch_icache_bank #(.PARITY(p)) u_bank (
            .clk(clk), .reset_i(reset_i), .valid_i(s2_valid), .xlat_i(s2_xlat),
            .fill_rsp_i(fill_rsp[p]), .fill_req_o(fill_req[p]), .line_o(line[p]));
    end

    assign fill_req_e_o = fill_req[0];
    assign fill_req_o_o = fill_req[1];
    assign line_e_o     = line[0];
    assign line_o_o     = line[1];

endmodule
